//--- hw/dcache_pkg.sv
package dcache_pkg;

    // cache geometry
    localparam int WAYS     = 4;
    localparam int SETS     = 256;
    localparam int OFFSET_W = 2;
    localparam int INDEX_W  = 8;
    localparam int TAG_W    = 22;
    localparam int DATA_W   = 32;
    localparam int LRU_W    = 2;

    typedef logic [DATA_W-1:0]        word_t;
    typedef logic [TAG_W-1:0]         tag_t;
    typedef logic [INDEX_W-1:0]       index_t;
    typedef logic [$clog2(WAYS)-1:0]  way_t;

    // miss handling phases
    typedef enum logic [1:0] {
        MISS_IDLE,
        MISS_WRITEBACK,
        MISS_REFILL
    } miss_state_t;

endpackage

//--- hw/cache_way_store.sv
module cache_way_store (
    input  logic              clk,
    input  logic              rst,
    input  dcache_pkg::index_t lookup_index,
    input  dcache_pkg::tag_t   lookup_tag,
    output logic              hit,
    output dcache_pkg::way_t   hit_way,
    output dcache_pkg::word_t  rdata,
    input  dcache_pkg::way_t   victim_way,
    output dcache_pkg::tag_t   victim_tag,
    output dcache_pkg::word_t  victim_data,
    output logic              victim_dirty,
    input  logic              write_hit,
    input  dcache_pkg::word_t  wdata,
    input  logic              fill,
    input  dcache_pkg::index_t fill_index,
    input  dcache_pkg::tag_t   fill_tag,
    input  dcache_pkg::way_t   fill_way,
    input  dcache_pkg::word_t  fill_data
);
    import dcache_pkg::*;

    logic  valid_arr [WAYS][SETS];
    logic  dirty_arr [WAYS][SETS];
    tag_t  tag_arr   [WAYS][SETS];
    word_t data_arr  [WAYS][SETS];

    // parallel tag compare, first matching way wins
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        rdata   = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (!hit && valid_arr[w][lookup_index] && tag_arr[w][lookup_index] == lookup_tag) begin
                hit     = 1'b1;
                hit_way = way_t'(w);
                rdata   = data_arr[w][lookup_index];
            end
        end
    end

    assign victim_tag   = tag_arr[victim_way][lookup_index];
    assign victim_data  = data_arr[victim_way][lookup_index];
    assign victim_dirty = valid_arr[victim_way][lookup_index] & dirty_arr[victim_way][lookup_index];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < WAYS; w++) begin
                for (int s = 0; s < SETS; s++) begin
                    valid_arr[w][s] <= 1'b0;
                    dirty_arr[w][s] <= 1'b0;
                end
            end
        end else if (fill) begin
            // refilled line arrives clean
            valid_arr[fill_way][fill_index] <= 1'b1;
            dirty_arr[fill_way][fill_index] <= 1'b0;
        end else if (write_hit) begin
            dirty_arr[hit_way][lookup_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            tag_arr[fill_way][fill_index]  <= fill_tag;
            data_arr[fill_way][fill_index] <= fill_data;
        end else if (write_hit) begin
            data_arr[hit_way][lookup_index] <= wdata;
        end
    end

endmodule

//--- hw/lru_tracker.sv
module lru_tracker (
    input  logic              clk,
    input  logic              rst,
    input  dcache_pkg::index_t index,
    input  logic              touch,
    input  dcache_pkg::way_t   touch_way,
    output dcache_pkg::way_t   victim_way
);
    import dcache_pkg::*;

    // age 3 is most recent, 0 is a replacement candidate
    logic [LRU_W-1:0] age [SETS][WAYS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < SETS; s++) begin
                for (int w = 0; w < WAYS; w++) begin
                    age[s][w] <= '0;
                end
            end
        end else if (touch) begin
            for (int w = 0; w < WAYS; w++) begin
                if (way_t'(w) == touch_way) begin
                    age[index][w] <= '1;
                end else if (age[index][w] > age[index][touch_way]) begin
                    age[index][w] <= age[index][w] - 1'b1;
                end
            end
        end
    end

    // lowest way with zero age, else the last way
    always_comb begin
        victim_way = way_t'(WAYS - 1);
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (age[index][w] == '0) begin
                victim_way = way_t'(w);
            end
        end
    end

endmodule

//--- hw/miss_controller.sv
module miss_controller (
    input  logic              clk,
    input  logic              rst,
    input  logic              req,
    input  logic              wr,
    input  dcache_pkg::word_t  addr,
    input  logic              hit,
    input  dcache_pkg::way_t   victim_way,
    input  dcache_pkg::tag_t   victim_tag,
    input  dcache_pkg::word_t  victim_data,
    input  logic              victim_dirty,
    output logic              addr_ok,
    output logic              data_ok,
    output logic              write_hit,
    output logic              touch,
    output logic              fill,
    output dcache_pkg::index_t fill_index,
    output dcache_pkg::tag_t   fill_tag,
    output dcache_pkg::way_t   fill_way,
    output dcache_pkg::word_t  fill_data,
    output logic              mem_req,
    output logic              mem_wr,
    output dcache_pkg::word_t  mem_addr,
    output dcache_pkg::word_t  mem_wdata,
    input  dcache_pkg::word_t  mem_rdata,
    input  logic              mem_addr_ok,
    input  logic              mem_data_ok
);
    import dcache_pkg::*;

    miss_state_t state;
    logic        addr_sent;
    index_t      cap_index;
    tag_t        cap_tag;
    way_t        cap_way;
    tag_t        wb_tag;
    word_t       wb_data;

    // hits are served only while no miss is in flight
    assign touch     = req & hit & (state == MISS_IDLE);
    assign addr_ok   = touch;
    assign data_ok   = touch;
    assign write_hit = touch & wr;

    assign fill       = (state == MISS_REFILL) & mem_data_ok;
    assign fill_index = cap_index;
    assign fill_tag   = cap_tag;
    assign fill_way   = cap_way;
    assign fill_data  = mem_rdata;

    assign mem_req   = (state != MISS_IDLE) & ~addr_sent;
    assign mem_wr    = (state == MISS_WRITEBACK);
    assign mem_addr  = mem_wr ? {wb_tag, cap_index, {OFFSET_W{1'b0}}}
                              : {cap_tag, cap_index, {OFFSET_W{1'b0}}};
    assign mem_wdata = wb_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= MISS_IDLE;
            addr_sent <= 1'b0;
        end else begin
            // address phase done, wait for the data phase
            if (mem_data_ok) begin
                addr_sent <= 1'b0;
            end else if (mem_req && mem_addr_ok) begin
                addr_sent <= 1'b1;
            end
            case (state)
                MISS_IDLE: begin
                    if (req && !hit) begin
                        state <= victim_dirty ? MISS_WRITEBACK : MISS_REFILL;
                    end
                end
                MISS_WRITEBACK: begin
                    if (mem_data_ok) begin
                        state <= MISS_REFILL;
                    end
                end
                MISS_REFILL: begin
                    if (mem_data_ok) begin
                        state <= MISS_IDLE;
                    end
                end
                default: state <= MISS_IDLE;
            endcase
        end
    end

    // request and victim snapshot at miss detection
    always_ff @(posedge clk) begin
        if (state == MISS_IDLE && req && !hit) begin
            cap_index <= addr[OFFSET_W +: INDEX_W];
            cap_tag   <= addr[DATA_W-1 -: TAG_W];
            cap_way   <= victim_way;
            wb_tag    <= victim_tag;
            wb_data   <= victim_data;
        end
    end

endmodule

//--- hw/dcache_top.sv
module dcache_top (
    input  logic             clk,
    input  logic             rst,
    input  logic             req,
    input  logic             wr,
    input  dcache_pkg::word_t addr,
    input  dcache_pkg::word_t wdata,
    output dcache_pkg::word_t rdata,
    output logic             addr_ok,
    output logic             data_ok,
    output logic             mem_req,
    output logic             mem_wr,
    output dcache_pkg::word_t mem_addr,
    output dcache_pkg::word_t mem_wdata,
    input  dcache_pkg::word_t mem_rdata,
    input  logic             mem_addr_ok,
    input  logic             mem_data_ok
);
    import dcache_pkg::*;

    index_t index;
    tag_t   tag;
    logic   hit;
    way_t   hit_way;
    way_t   victim_way;
    tag_t   victim_tag;
    word_t  victim_data;
    logic   victim_dirty;
    logic   write_hit;
    logic   touch;
    logic   fill;
    index_t fill_index;
    tag_t   fill_tag;
    way_t   fill_way;
    word_t  fill_data;

    assign index = addr[OFFSET_W +: INDEX_W];
    assign tag   = addr[DATA_W-1 -: TAG_W];

    cache_way_store i_store (
        .clk          (clk),
        .rst          (rst),
        .lookup_index (index),
        .lookup_tag   (tag),
        .hit          (hit),
        .hit_way      (hit_way),
        .rdata        (rdata),
        .victim_way   (victim_way),
        .victim_tag   (victim_tag),
        .victim_data  (victim_data),
        .victim_dirty (victim_dirty),
        .write_hit    (write_hit),
        .wdata        (wdata),
        .fill         (fill),
        .fill_index   (fill_index),
        .fill_tag     (fill_tag),
        .fill_way     (fill_way),
        .fill_data    (fill_data)
    );

    lru_tracker i_lru (
        .clk        (clk),
        .rst        (rst),
        .index      (index),
        .touch      (touch),
        .touch_way  (hit_way),
        .victim_way (victim_way)
    );

    miss_controller i_ctrl (
        .clk          (clk),
        .rst          (rst),
        .req          (req),
        .wr           (wr),
        .addr         (addr),
        .hit          (hit),
        .victim_way   (victim_way),
        .victim_tag   (victim_tag),
        .victim_data  (victim_data),
        .victim_dirty (victim_dirty),
        .addr_ok      (addr_ok),
        .data_ok      (data_ok),
        .write_hit    (write_hit),
        .touch        (touch),
        .fill         (fill),
        .fill_index   (fill_index),
        .fill_tag     (fill_tag),
        .fill_way     (fill_way),
        .fill_data    (fill_data),
        .mem_req      (mem_req),
        .mem_wr       (mem_wr),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_rdata    (mem_rdata),
        .mem_addr_ok  (mem_addr_ok),
        .mem_data_ok  (mem_data_ok)
    );

endmodule

//--- dv/mem_model.sv
module mem_model (
    input  logic              clk,
    input  logic              rst,
    input  logic              mem_req,
    input  logic              mem_wr,
    input  dcache_pkg::word_t mem_addr,
    input  dcache_pkg::word_t mem_wdata,
    output dcache_pkg::word_t mem_rdata,
    output logic              mem_addr_ok,
    output logic              mem_data_ok
);
    timeunit 1ns;
    timeprecision 1ps;
    import dcache_pkg::*;

    localparam int MEM_WORDS = 16384;
    localparam int MAX_DELAY = 4;

    // 64 KiB window, indexed by addr[15:2]
    word_t mem [MEM_WORDS];
    word_t wr_log [$];
    int    txn_count;
    int    seed;
    int    delay;
    logic  busy;
    logic  cur_wr;
    word_t cur_addr;
    word_t cur_wdata;

    function automatic word_t initial_word(input word_t a);
        return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]} ^ 32'h5a5a_c3c3;
    endfunction

    initial begin
        seed = 67662;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = initial_word(word_t'(i) << OFFSET_W);
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            mem_addr_ok <= 1'b0;
            mem_data_ok <= 1'b0;
            mem_rdata   <= '0;
            busy        <= 1'b0;
            delay       <= 0;
            txn_count   <= 0;
        end else begin
            mem_data_ok <= 1'b0;
            if (mem_addr_ok) begin
                // fields are still held in the accepting cycle
                mem_addr_ok <= 1'b0;
                busy        <= 1'b1;
                cur_wr      <= mem_wr;
                cur_addr    <= mem_addr;
                cur_wdata   <= mem_wdata;
                delay       <= 1 + ($unsigned($random(seed)) % MAX_DELAY);
                txn_count   <= txn_count + 1;
            end else if (busy) begin
                if (delay == 1) begin
                    busy        <= 1'b0;
                    mem_data_ok <= 1'b1;
                    if (cur_wr) begin
                        mem[cur_addr[15:2]] = cur_wdata;
                        wr_log.push_back(cur_addr);
                    end else begin
                        mem_rdata <= mem[cur_addr[15:2]];
                    end
                end else begin
                    delay <= delay - 1;
                end
            end else if (mem_req) begin
                mem_addr_ok <= 1'b1;
            end
        end
    end

endmodule

//--- dv/dcache_assert.sv
module dcache_assert (
    input logic              clk,
    input logic              rst,
    input logic              req,
    input logic              addr_ok,
    input logic              data_ok,
    input logic              mem_req,
    input logic              mem_wr,
    input dcache_pkg::word_t mem_addr,
    input dcache_pkg::word_t mem_wdata,
    input logic              mem_addr_ok
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    // address phase held until accepted
    mem_req_held: assert property (@(posedge clk) disable iff (rst)
        mem_req && !mem_addr_ok |=> mem_req && $stable(mem_wr) && $stable(mem_addr)
            && $stable(mem_wdata))
        else begin
            $error("mem_req dropped or its fields changed before mem_addr_ok");
            fail_count++;
        end

    data_ok_with_addr_ok: assert property (@(posedge clk) disable iff (rst)
        data_ok |-> addr_ok)
        else begin
            $error("data_ok high without addr_ok");
            fail_count++;
        end

    strobes_need_req: assert property (@(posedge clk) disable iff (rst)
        (addr_ok || data_ok) |-> req)
        else begin
            $error("addr_ok or data_ok high without req");
            fail_count++;
        end

    mem_req_idle_after_reset: assert property (@(posedge clk) rst |=> !mem_req)
        else begin
            $error("mem_req high in the cycle after reset");
            fail_count++;
        end

endmodule

//--- dv/tb_dcache.sv
module tb_dcache;
    timeunit 1ns;
    timeprecision 1ps;
    import dcache_pkg::*;

    localparam int RAND_OPS    = 400;
    localparam int N_REQUESTS  = 2 + 2 + 5 + 6 + RAND_OPS;
    localparam int WATCHDOG_NS = N_REQUESTS * 12 * 8 + 4000;

    logic  clk = 1'b0;
    logic  rst, req, wr, addr_ok, data_ok;
    word_t addr, wdata, rdata;
    logic  mem_req, mem_wr, mem_addr_ok, mem_data_ok;
    word_t mem_addr, mem_wdata, mem_rdata;

    // shadow memory and shadow cache state
    word_t            shadow [word_t];
    logic [LRU_W-1:0] ref_age   [SETS][WAYS] = '{default: '0};
    logic             ref_valid [SETS][WAYS] = '{default: '0};
    logic             ref_dirty [SETS][WAYS] = '{default: '0};
    tag_t             ref_tag   [SETS][WAYS] = '{default: '0};
    string            test_name = "reset";
    int               log_seen = 0;
    int               seed = 67662;

    always #4 clk = ~clk;

    dcache_top i_dut (
        .clk(clk), .rst(rst), .req(req), .wr(wr), .addr(addr), .wdata(wdata),
        .rdata(rdata), .addr_ok(addr_ok), .data_ok(data_ok),
        .mem_req(mem_req), .mem_wr(mem_wr), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
        .mem_rdata(mem_rdata), .mem_addr_ok(mem_addr_ok), .mem_data_ok(mem_data_ok)
    );

    mem_model i_mem (
        .clk(clk), .rst(rst), .mem_req(mem_req), .mem_wr(mem_wr), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_rdata(mem_rdata), .mem_addr_ok(mem_addr_ok),
        .mem_data_ok(mem_data_ok)
    );

    bind dcache_top dcache_assert i_assert (
        .clk(clk), .rst(rst), .req(req), .addr_ok(addr_ok), .data_ok(data_ok),
        .mem_req(mem_req), .mem_wr(mem_wr), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_addr_ok(mem_addr_ok)
    );

    task automatic abort_run();
        $display("RESULT: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic report_mismatch(input string what, input word_t expected, input word_t actual);
        $display("MISMATCH %s (%s): expected %h, actual %h", test_name, what, expected, actual);
        abort_run();
    endtask

    function automatic word_t initial_word(input word_t a);
        return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]} ^ 32'h5a5a_c3c3;
    endfunction

    function automatic word_t expected_read(input word_t a);
        return shadow.exists(a) ? shadow[a] : initial_word(a);
    endfunction

    function automatic word_t line_addr(input int tag, input int set);
        return word_t'((tag << (INDEX_W + OFFSET_W)) | (set << OFFSET_W));
    endfunction

    // replays one access on the shadow cache and flags a dirty eviction
    function automatic logic expected_access(input word_t a, input logic is_wr,
                                             output word_t wb_addr);
        index_t           s;
        tag_t             t;
        int               way;
        logic [LRU_W-1:0] base_age;
        logic             wb;
        s       = a[OFFSET_W +: INDEX_W];
        t       = a[DATA_W-1 -: TAG_W];
        way     = -1;
        wb      = 1'b0;
        wb_addr = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (ref_valid[s][w] && ref_tag[s][w] == t) begin
                way = w;
            end
        end
        if (way < 0) begin
            // lowest way with age zero or else the last way
            for (int w = 0; w < WAYS; w++) begin
                if (way < 0 && ref_age[s][w] == '0) begin
                    way = w;
                end
            end
            if (way < 0) begin
                way = WAYS - 1;
            end
            wb      = ref_valid[s][way] & ref_dirty[s][way];
            wb_addr = {ref_tag[s][way], s, {OFFSET_W{1'b0}}};
            ref_valid[s][way] = 1'b1;
            ref_dirty[s][way] = 1'b0;
            ref_tag[s][way]   = t;
        end
        base_age = ref_age[s][way];
        for (int w = 0; w < WAYS; w++) begin
            if (w != way && ref_age[s][w] > base_age) begin
                ref_age[s][w] = ref_age[s][w] - 1'b1;
            end
        end
        ref_age[s][way] = '1;
        if (is_wr) begin
            ref_dirty[s][way] = 1'b1;
        end
        return wb;
    endfunction

    task automatic cpu_access(input logic is_wr, input word_t a, input word_t d,
                              output int cycles);
        @(posedge clk);
        req   <= 1'b1;
        wr    <= is_wr;
        addr  <= a;
        wdata <= d;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (!data_ok);
        req <= 1'b0;
    endtask

    // checks every completed request
    always @(posedge clk) begin
        word_t exp;
        word_t wb_addr;
        logic  wb_exp;
        int    n_new;
        if (!rst) begin
            assert (i_dut.i_assert.fail_count == 0) else begin
                $display("ERROR: a protocol assertion on the DUT ports failed");
                abort_run();
            end
            assert (addr_ok == data_ok) else begin
                $display("ERROR: addr_ok and data_ok were not high in the same cycle");
                abort_run();
            end
            if (data_ok) begin
                if (!wr) begin
                    exp = expected_read(addr);
                    assert (rdata == exp) else report_mismatch("read data", exp, rdata);
                end
                wb_exp = expected_access(addr, wr, wb_addr);
                n_new  = i_mem.wr_log.size() - log_seen;
                assert (n_new == (wb_exp ? 1 : 0))
                    else report_mismatch("write-back count", word_t'(wb_exp), word_t'(n_new));
                if (wb_exp) begin
                    assert (i_mem.wr_log[log_seen] == wb_addr)
                        else report_mismatch("write-back address", wb_addr, i_mem.wr_log[log_seen]);
                    exp = expected_read(wb_addr);
                    assert (i_mem.mem[wb_addr[15:2]] == exp)
                        else report_mismatch("written-back data", exp, i_mem.mem[wb_addr[15:2]]);
                end
                log_seen = i_mem.wr_log.size();
                if (wr) begin
                    shadow[addr] = wdata;
                end
            end
        end
    end

    initial begin
        int    cycles;
        int    count_before;
        word_t r;
        rst   <= 1'b1;
        req   <= 1'b0;
        wr    <= 1'b0;
        addr  <= '0;
        wdata <= '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        test_name = "cold read then hit";
        cpu_access(1'b0, line_addr(1, 4), '0, cycles);
        count_before = i_mem.txn_count;
        cpu_access(1'b0, line_addr(1, 4), '0, cycles);
        assert (cycles == 1) else report_mismatch("hit latency", 32'd1, word_t'(cycles));
        assert (i_mem.txn_count == count_before)
            else report_mismatch("memory transactions", word_t'(count_before),
                                 word_t'(i_mem.txn_count));

        test_name = "write hit";
        count_before = i_mem.wr_log.size();
        cpu_access(1'b1, line_addr(1, 4), 32'hcafe_0001, cycles);
        cpu_access(1'b0, line_addr(1, 4), '0, cycles);
        assert (i_mem.wr_log.size() == count_before)
            else report_mismatch("memory writes", word_t'(count_before),
                                 word_t'(i_mem.wr_log.size()));

        test_name = "five tags in one set";
        count_before = i_mem.wr_log.size();
        for (int i = 1; i <= 5; i++) begin
            cpu_access(1'b1, line_addr(i, 20), 32'h3000_0000 + word_t'(i), cycles);
        end
        assert (i_mem.wr_log.size() == count_before + 1)
            else report_mismatch("memory writes", word_t'(count_before + 1),
                                 word_t'(i_mem.wr_log.size()));
        assert (i_mem.wr_log[count_before] == line_addr(1, 20))
            else report_mismatch("write-back address", line_addr(1, 20),
                                 i_mem.wr_log[count_before]);
        assert (i_mem.mem[line_addr(1, 20) >> OFFSET_W] == 32'h3000_0001)
            else report_mismatch("memory word", 32'h3000_0001,
                                 i_mem.mem[line_addr(1, 20) >> OFFSET_W]);

        test_name = "lru order";
        for (int i = 11; i <= 14; i++) begin
            cpu_access(1'b1, line_addr(i, 33), 32'h4000_0000 + word_t'(i), cycles);
        end
        cpu_access(1'b0, line_addr(11, 33), '0, cycles);
        count_before = i_mem.wr_log.size();
        cpu_access(1'b1, line_addr(15, 33), 32'h4000_000f, cycles);
        assert (i_mem.wr_log.size() == count_before + 1 && i_mem.wr_log[count_before] ==
                line_addr(12, 33))
            else report_mismatch("evicted line", line_addr(12, 33), i_mem.wr_log[$]);

        // 16 addresses over sets 50 and 51 with tags 20 to 27
        test_name = "random traffic";
        for (int i = 0; i < RAND_OPS; i++) begin
            r = $random(seed);
            cpu_access(r[0], line_addr(20 + int'(r[3:1]), 50 + int'(r[4])), r, cycles);
        end

        repeat (2) @(posedge clk);
        if (i_dut.i_assert.fail_count == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            $display("ERROR: a protocol assertion on the DUT ports failed");
            abort_run();
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("ERROR: timeout after %0d ns, the cache stopped completing requests",
                 WATCHDOG_NS);
        abort_run();
    end

endmodule

//--- tb.f
hw/dcache_pkg.sv
hw/cache_way_store.sv
hw/lru_tracker.sv
hw/miss_controller.sv
hw/dcache_top.sv
dv/mem_model.sv
dv/dcache_assert.sv
dv/tb_dcache.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = tb_dcache
FILELIST  = tb.f
OBJ_DIR   = obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
		echo "$$out" | grep -qx 'RESULT: PASS'

clean:
	rm -rf $(OBJ_DIR)
